/* common/muldiv_macros.svh */
`ifndef MULDIV_MACROS_SVH
`define MULDIV_MACROS_SVH

// operand and result word width
`define MULDIV_XLEN 32

// product is two words wide
`define MULDIV_PROD_W (2 * `MULDIV_XLEN)

// one iteration per operand bit
`define MULDIV_STEPS `MULDIV_XLEN

// step counter, must cover MULDIV_STEPS - 1
`define MULDIV_IDX_W 5

`endif

/* common/muldiv_pkg.sv */
`default_nettype none

`include "muldiv_macros.svh"

package muldiv_pkg;

    // same order as funct3 of the M extension
    typedef enum logic [2:0] {
        OP_MUL    = 3'd0,
        OP_MULH   = 3'd1,
        OP_MULHSU = 3'd2,
        OP_MULHU  = 3'd3,
        OP_DIV    = 3'd4,
        OP_DIVU   = 3'd5,
        OP_REM    = 3'd6,
        OP_REMU   = 3'd7
    } muldiv_op_e;

    // one-hot encoded controller states
    typedef enum logic [2:0] {
        ST_IDLE  = 3'b001,
        ST_CALC  = 3'b010,
        ST_FIXUP = 3'b100
    } muldiv_state_e;

    typedef struct packed {
        muldiv_op_e             op;
        logic [`MULDIV_XLEN-1:0] rs1;
        logic [`MULDIV_XLEN-1:0] rs2;
    } muldiv_req_t;

    // registered operation, signs already folded into flags
    typedef struct packed {
        muldiv_op_e             op;
        logic [`MULDIV_XLEN-1:0] a_abs;
        logic [`MULDIV_XLEN-1:0] b_abs;
        logic                   neg_main;  // product / quotient negated
        logic                   neg_rem;   // remainder follows dividend sign
        logic                   div_zero;
        logic                   div_ovf;   // min int / -1
        logic [`MULDIV_XLEN-1:0] rs1_raw;  // returned as-is on corner cases
    } muldiv_operand_t;

endpackage

`default_nettype wire

/* muldiv/operand_prep.sv */
`timescale 1ns/1ns
`default_nettype none

`include "muldiv_macros.svh"

module operand_prep
    import muldiv_pkg::*;
(
    input  wire logic            clk,
    input  wire logic            resetn,
    input  wire logic            load,
    input  wire muldiv_req_t     req,
    output muldiv_operand_t      opnd
);

    localparam logic [`MULDIV_XLEN-1:0] MIN_INT = {1'b1, {(`MULDIV_XLEN-1){1'b0}}};

    logic a_signed;
    logic b_signed;
    logic a_neg;
    logic b_neg;
    logic signed_div;

    // MUL low word is sign independent, treat as unsigned
    assign a_signed   = req.op inside {OP_MULH, OP_MULHSU, OP_DIV, OP_REM};
    assign b_signed   = req.op inside {OP_MULH, OP_DIV, OP_REM};
    assign signed_div = req.op inside {OP_DIV, OP_REM};

    assign a_neg = a_signed && req.rs1[`MULDIV_XLEN-1];
    assign b_neg = b_signed && req.rs2[`MULDIV_XLEN-1];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            opnd <= '0;
        end else if (load) begin
            opnd.op       <= req.op;
            opnd.a_abs    <= a_neg ? (~req.rs1 + 1'b1) : req.rs1;  // min int stays as is
            opnd.b_abs    <= b_neg ? (~req.rs2 + 1'b1) : req.rs2;
            opnd.neg_main <= a_neg ^ b_neg;
            opnd.neg_rem  <= a_neg;   // remainder sign of dividend
            opnd.div_zero <= (req.rs2 == '0);
            opnd.div_ovf  <= signed_div && (req.rs1 == MIN_INT) && (&req.rs2);
            opnd.rs1_raw  <= req.rs1;
        end
    end

endmodule

`default_nettype wire

/* muldiv/shift_add_mul.sv */
`timescale 1ns/1ns
`default_nettype none

`include "muldiv_macros.svh"

module shift_add_mul
    import muldiv_pkg::*;
(
    input  wire logic                     clk,
    input  wire logic                     resetn,
    input  wire logic                     load,
    input  wire logic                     mul_step,
    input  wire logic [`MULDIV_IDX_W-1:0] step_idx,
    input  wire muldiv_operand_t          opnd,
    output logic [`MULDIV_PROD_W-1:0]     prod
);

    logic [`MULDIV_PROD_W-1:0] mcand_ext;
    logic [`MULDIV_PROD_W-1:0] partial;
    logic                      mplier_bit;

    // multiplicand zero extended to product width
    assign mcand_ext = {{`MULDIV_XLEN{1'b0}}, opnd.a_abs};

    // current multiplier bit, lsb first
    assign mplier_bit = opnd.b_abs[step_idx];

    // shifted multiplicand or nothing
    assign partial = mplier_bit ? (mcand_ext << step_idx) : '0;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            prod <= '0;
        end else if (load) begin
            prod <= '0;               // fresh accumulation
        end else if (mul_step) begin
            prod <= prod + partial;   // unsigned, sign applied in fixup
        end
    end

endmodule

`default_nettype wire

/* muldiv/restoring_div.sv */
`timescale 1ns/1ns
`default_nettype none

`include "muldiv_macros.svh"

module restoring_div
    import muldiv_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  resetn,
    input  wire logic                  load,
    input  wire logic                  div_step,
    input  wire muldiv_operand_t       opnd,
    output logic [`MULDIV_XLEN-1:0]    quot,
    output logic [`MULDIV_XLEN-1:0]    rem
);

    localparam int XW = `MULDIV_XLEN;

    logic [XW-1:0] q_r;      // dividend bits out at top, quotient bits in at bottom
    logic [XW-1:0] rem_r;    // partial remainder
    logic          fresh;    // first step still ahead
    logic [XW-1:0] dvd;
    logic [XW:0]   shifted;
    logic [XW+1:0] diff;
    logic          borrow;

    // operands land with load, so first step reads them directly
    assign dvd = fresh ? opnd.a_abs : q_r;

    // bring down next dividend bit
    assign shifted = {rem_r, dvd[XW-1]};

    // trial subtract, one extra bit for the borrow
    assign diff   = {1'b0, shifted} - {2'b00, opnd.b_abs};
    assign borrow = diff[XW+1];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            fresh <= 1'b0;
            q_r   <= '0;
            rem_r <= '0;
        end else if (load) begin
            fresh <= 1'b1;
            rem_r <= '0;
        end else if (div_step) begin
            fresh <= 1'b0;
            q_r   <= {dvd[XW-2:0], ~borrow};
            // keep difference only when it fits
            rem_r <= borrow ? shifted[XW-1:0] : diff[XW-1:0];
        end
    end

    // unsigned results, signs fixed later
    assign quot = q_r;
    assign rem  = rem_r;

endmodule

`default_nettype wire

/* muldiv/result_fixup.sv */
`timescale 1ns/1ns
`default_nettype none

`include "muldiv_macros.svh"

module result_fixup
    import muldiv_pkg::*;
(
    input  wire logic                      clk,
    input  wire logic                      resetn,
    input  wire logic                      fixup,
    input  wire muldiv_operand_t           opnd,
    input  wire logic [`MULDIV_PROD_W-1:0] prod,
    input  wire logic [`MULDIV_XLEN-1:0]   quot,
    input  wire logic [`MULDIV_XLEN-1:0]   rem,
    output logic [`MULDIV_XLEN-1:0]        result
);

    logic [`MULDIV_PROD_W-1:0] prod_s;
    logic [`MULDIV_XLEN-1:0]   quot_s;
    logic [`MULDIV_XLEN-1:0]   rem_s;
    logic [`MULDIV_XLEN-1:0]   sel;

    // negate the whole product so borrow reaches the high word
    assign prod_s = opnd.neg_main ? (~prod + 1'b1) : prod;
    assign quot_s = opnd.neg_main ? (~quot + 1'b1) : quot;
    assign rem_s  = opnd.neg_rem  ? (~rem + 1'b1)  : rem;

    always_comb begin
        case (opnd.op)
            OP_MUL:                       sel = prod[`MULDIV_XLEN-1:0];
            OP_MULH, OP_MULHSU, OP_MULHU: sel = prod_s[`MULDIV_PROD_W-1:`MULDIV_XLEN];
            OP_DIV, OP_DIVU: begin
                if (opnd.div_zero) begin
                    sel = '1;            // all ones
                end else if (opnd.div_ovf) begin
                    sel = opnd.rs1_raw;  // min int back
                end else begin
                    sel = quot_s;
                end
            end
            default: begin
                // REM / REMU
                if (opnd.div_zero) begin
                    sel = opnd.rs1_raw;
                end else if (opnd.div_ovf) begin
                    sel = '0;
                end else begin
                    sel = rem_s;
                end
            end
        endcase
    end

    // held until next fixup
    always_ff @(posedge clk) begin
        if (!resetn) begin
            result <= '0;
        end else if (fixup) begin
            result <= sel;
        end
    end

endmodule

`default_nettype wire

/* source/muldiv_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

`include "muldiv_macros.svh"

module muldiv_ctrl
    import muldiv_pkg::*;
(
    input  wire logic                     clk,
    input  wire logic                     resetn,
    input  wire logic                     valid,
    input  wire muldiv_op_e               op,        // from registered operand
    output logic                          load,
    output logic                          mul_step,
    output logic                          div_step,
    output logic [`MULDIV_IDX_W-1:0]      step_idx,
    output logic                          fixup,
    output logic                          ready
);

    localparam int LAST_STEP = `MULDIV_STEPS - 1;

    muldiv_state_e state;
    logic          in_calc;
    logic          is_div;
    logic          last_step;

    // division ops drive the divider, the rest the multiplier
    assign is_div = op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};

    assign in_calc   = (state == ST_CALC);
    assign last_step = (step_idx == LAST_STEP[`MULDIV_IDX_W-1:0]);

    // accept only when idle and no done pulse pending
    assign load = (state == ST_IDLE) && valid && !ready;

    assign mul_step = in_calc && !is_div;
    assign div_step = in_calc && is_div;
    assign fixup    = (state == ST_FIXUP);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state    <= ST_IDLE;
            step_idx <= '0;
            ready    <= 1'b0;
        end else begin
            ready <= 1'b0;  // pulse lasts one cycle only
            case (state)
                ST_IDLE: begin
                    if (load) begin
                        step_idx <= '0;
                        state    <= ST_CALC;  // E0
                    end
                end
                ST_CALC: begin
                    // steps on E1 .. E32
                    step_idx <= step_idx + 1'b1;
                    if (last_step) begin
                        state <= ST_FIXUP;
                    end
                end
                ST_FIXUP: begin
                    // result latched this edge too
                    ready <= 1'b1;
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;  // recover from illegal encoding
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/muldiv_unit.sv */
`timescale 1ns/1ns
`default_nettype none

`include "muldiv_macros.svh"

module muldiv_unit
    import muldiv_pkg::*;
(
    input  wire logic                    clk,
    input  wire logic                    resetn,
    input  wire logic                    valid,   // one-cycle request strobe
    input  wire muldiv_req_t             req,
    output logic [`MULDIV_XLEN-1:0]      result,
    output logic                         ready    // one-cycle done pulse
);

    logic                        load;
    logic                        mul_step;
    logic                        div_step;
    logic                        fixup;
    logic [`MULDIV_IDX_W-1:0]    step_idx;
    muldiv_operand_t             opnd;
    logic [`MULDIV_PROD_W-1:0]   prod;
    logic [`MULDIV_XLEN-1:0]     quot;
    logic [`MULDIV_XLEN-1:0]     rem;

    // sequencer, op class comes from registered operand
    muldiv_ctrl u_ctrl (
        .clk      (clk),
        .resetn   (resetn),
        .valid    (valid),
        .op       (opnd.op),
        .load     (load),
        .mul_step (mul_step),
        .div_step (div_step),
        .step_idx (step_idx),
        .fixup    (fixup),
        .ready    (ready)
    );

    operand_prep u_prep (
        .clk    (clk),
        .resetn (resetn),
        .load   (load),
        .req    (req),
        .opnd   (opnd)
    );

    shift_add_mul u_mul (
        .clk      (clk),
        .resetn   (resetn),
        .load     (load),
        .mul_step (mul_step),
        .step_idx (step_idx),
        .opnd     (opnd),
        .prod     (prod)
    );

    restoring_div u_div (
        .clk      (clk),
        .resetn   (resetn),
        .load     (load),
        .div_step (div_step),
        .opnd     (opnd),
        .quot     (quot),
        .rem      (rem)
    );

    // picks word, applies sign and corner values
    result_fixup u_fixup (
        .clk    (clk),
        .resetn (resetn),
        .fixup  (fixup),
        .opnd   (opnd),
        .prod   (prod),
        .quot   (quot),
        .rem    (rem),
        .result (result)
    );

endmodule

`default_nettype wire

/* verification/muldiv_checker.sv */
`timescale 1ns/1ns
`default_nettype none

`include "muldiv_macros.svh"

module muldiv_checker
    import muldiv_pkg::*;
(
    input wire logic          clk,
    input wire logic          resetn,
    input wire logic          load,     // acceptance strobe inside the unit
    input wire logic          ready,
    input wire muldiv_state_e state
);

    // ready stays low while sampled on E1 .. E33
    localparam int BUSY_CYCLES = `MULDIV_STEPS + 1;

    int fail_count = 0;  // polled by the testbench

    // done strobe is one cycle wide
    a_ready_pulse: assert property (@(posedge clk) disable iff (!resetn)
        ready |=> !ready)
    else begin
        fail_count++;
        $error("ready stayed high for two cycles");
    end

    // fixed latency from acceptance to done
    a_latency: assert property (@(posedge clk) disable iff (!resetn)
        load |=> (!ready [*BUSY_CYCLES]) ##1 ready)
    else begin
        fail_count++;
        $error("ready did not follow the accepted request on time");
    end

    // clean state right after reset
    a_reset_state: assert property (@(posedge clk)
        !resetn |=> (!ready && (state == ST_IDLE)))
    else begin
        fail_count++;
        $error("ready or state not cleared by reset");
    end

endmodule

bind muldiv_unit muldiv_checker u_checker (
    .clk    (clk),
    .resetn (resetn),
    .load   (load),
    .ready  (ready),
    .state  (u_ctrl.state)
);

`default_nettype wire

/* verification/muldiv_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "muldiv_macros.svh"

module muldiv_tb
    import muldiv_pkg::*;
();

    localparam int XW       = `MULDIV_XLEN;
    localparam int LATENCY  = `MULDIV_STEPS + 2;  // accept edge counted as first
    localparam int TIMEOUT  = 50;
    localparam int N_RANDOM = 40;

    typedef struct packed {
        muldiv_req_t   req;
        logic [XW-1:0] exp;
    } vec_t;

    logic          clk;
    logic          resetn;
    logic          valid;
    muldiv_req_t   req;
    logic [XW-1:0] result;
    logic          ready;

    vec_t          vecs[$];   // vector table
    string         names[$];
    logic [31:0]   lfsr;

    muldiv_unit dut0 (
        .clk    (clk),
        .resetn (resetn),
        .valid  (valid),
        .req    (req),
        .result (result),
        .ready  (ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_result(input string name, input logic [XW-1:0] exp,
                                input logic [XW-1:0] act);
        if (act !== exp)
            fail_now($sformatf("mismatch %s: expected %h actual %h", name, exp, act));
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        if (act != exp)
            fail_now($sformatf("mismatch %s latency: expected %0d actual %0d", name, exp, act));
    endtask

    task automatic check_op(input string name, input muldiv_op_e exp, input muldiv_op_e act);
        if (act !== exp)
            fail_now($sformatf("mismatch %s op: expected %s actual %s", name, exp.name(),
                               act.name()));
    endtask

    task automatic check_assertions(input string name);
        if (dut0.u_checker.fail_count != 0)
            fail_now($sformatf("a bound assertion fired during %s", name));
    endtask

    function automatic void add_vec(input string name, input muldiv_op_e op,
                                    input logic [XW-1:0] rs1, input logic [XW-1:0] rs2,
                                    input logic [XW-1:0] exp);
        vec_t v;
        v.req.op  = op;
        v.req.rs1 = rs1;
        v.req.rs2 = rs2;
        v.exp     = exp;
        vecs.push_back(v);
        names.push_back(name);
    endfunction

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // risc-v m rules on 64-bit ints
    function automatic logic [XW-1:0] ref_model(input muldiv_op_e op, input logic [XW-1:0] a,
                                                input logic [XW-1:0] b);
        longint sa;
        longint sb;
        longint ua;
        longint ub;
        longint r;
        sa = {{XW{a[XW-1]}}, a};
        sb = {{XW{b[XW-1]}}, b};
        ua = {{XW{1'b0}}, a};
        ub = {{XW{1'b0}}, b};
        case (op)
            OP_MUL:    r = sa * sb;
            OP_MULH:   r = (sa * sb) >>> XW;
            OP_MULHSU: r = (sa * ub) >>> XW;
            OP_MULHU:  r = (ua * ub) >> XW;  // wraps mod 2^64, bits still right
            OP_DIV:    r = (b == 0) ? -1 : sa / sb;  // truncates toward zero
            OP_DIVU:   r = (b == 0) ? -1 : ua / ub;
            OP_REM:    r = (b == 0) ? sa : sa % sb;  // sign of dividend
            default:   r = (b == 0) ? ua : ua % ub;
        endcase
        return r[XW-1:0];
    endfunction

    function automatic void build_table();
        add_vec("mul_small",    OP_MUL,    32'd7,        32'd6,        32'h0000002a);
        add_vec("mul_neg_pos",  OP_MUL,    32'hfffffffd, 32'd5,        32'hfffffff1);
        add_vec("mul_neg_neg",  OP_MUL,    32'hfffffffd, 32'hfffffffb, 32'h0000000f);
        add_vec("mul_min",      OP_MUL,    32'h80000000, 32'hffffffff, 32'h80000000);
        add_vec("mulh_min_min", OP_MULH,   32'h80000000, 32'h80000000, 32'h40000000);
        add_vec("mulh_m1_m1",   OP_MULH,   32'hffffffff, 32'hffffffff, 32'h00000000);
        add_vec("mulh_mixed",   OP_MULH,   32'hfffffffe, 32'd3,        32'hffffffff);
        add_vec("mulh_max",     OP_MULH,   32'h7fffffff, 32'h7fffffff, 32'h3fffffff);
        add_vec("mulhsu_m1",    OP_MULHSU, 32'hffffffff, 32'hffffffff, 32'hffffffff);
        add_vec("mulhsu_min",   OP_MULHSU, 32'h80000000, 32'd2,        32'hffffffff);
        add_vec("mulhsu_pos",   OP_MULHSU, 32'd2,        32'hffffffff, 32'h00000001);
        add_vec("mulhu_max",    OP_MULHU,  32'hffffffff, 32'hffffffff, 32'hfffffffe);
        add_vec("mulhu_min",    OP_MULHU,  32'h80000000, 32'd2,        32'h00000001);
        add_vec("div_pp",       OP_DIV,    32'd20,       32'd6,        32'h00000003);
        add_vec("div_np",       OP_DIV,    32'hffffffec, 32'd6,        32'hfffffffd);
        add_vec("div_pn",       OP_DIV,    32'd20,       32'hfffffffa, 32'hfffffffd);
        add_vec("div_nn",       OP_DIV,    32'hffffffec, 32'hfffffffa, 32'h00000003);
        add_vec("div_min_2",    OP_DIV,    32'h80000000, 32'd2,        32'hc0000000);
        add_vec("divu_big",     OP_DIVU,   32'hffffffec, 32'd6,        32'h2aaaaaa7);
        add_vec("rem_pp",       OP_REM,    32'd20,       32'd6,        32'h00000002);
        add_vec("rem_np",       OP_REM,    32'hffffffec, 32'd6,        32'hfffffffe);
        add_vec("rem_pn",       OP_REM,    32'd20,       32'hfffffffa, 32'h00000002);
        add_vec("rem_nn",       OP_REM,    32'hffffffec, 32'hfffffffa, 32'hfffffffe);
        add_vec("remu_big",     OP_REMU,   32'hffffffec, 32'd6,        32'h00000002);
        add_vec("div_zero",     OP_DIV,    32'h0000007b, 32'd0,        32'hffffffff);
        add_vec("divu_zero",    OP_DIVU,   32'h0000007b, 32'd0,        32'hffffffff);
        add_vec("rem_zero",     OP_REM,    32'hffffff85, 32'd0,        32'hffffff85);
        add_vec("remu_zero",    OP_REMU,   32'd5,        32'd0,        32'h00000005);
        add_vec("div_ovf",      OP_DIV,    32'h80000000, 32'hffffffff, 32'h80000000);
        add_vec("rem_ovf",      OP_REM,    32'h80000000, 32'hffffffff, 32'h00000000);
        add_vec("divu_min_m1",  OP_DIVU,   32'h80000000, 32'hffffffff, 32'h00000000);
        add_vec("remu_min_m1",  OP_REMU,   32'h80000000, 32'hffffffff, 32'h80000000);
    endfunction

    // one request, optional stray valid while busy
    task automatic run_vec(input string name, input vec_t v, input bit intrude);
        int cycles;
        int waited;
        @(negedge clk);
        req   = v.req;
        valid = 1'b1;
        @(posedge clk);  // acceptance edge
        cycles = 1;
        @(negedge clk);
        check_op(name, v.req.op, dut0.opnd.op);
        waited = 0;
        while (!ready) begin
            if (waited == TIMEOUT)
                fail_now($sformatf("no ready for %s within %0d cycles", name, TIMEOUT));
            if (intrude && (waited == 5)) begin
                valid   = 1'b1;          // must be ignored
                req.rs1 = ~v.req.rs1;
            end else begin
                valid = 1'b0;
            end
            @(posedge clk);
            cycles++;
            @(negedge clk);
            waited++;
        end
        valid = 1'b0;
        check_latency(name, LATENCY, cycles);
        check_result(name, v.exp, result);
        // idle a while, result must hold and no second pulse
        repeat (4) begin
            @(negedge clk);
            if (ready)
                fail_now($sformatf("ready pulsed again after %s with no new request", name));
        end
        check_result({name, "_held"}, v.exp, result);
        check_assertions(name);
    endtask

    initial begin
        muldiv_req_t rq;
        logic [31:0] bits;
        resetn = 1'b0;
        valid  = 1'b0;
        req    = '0;
        lfsr   = 32'd17;
        repeat (2) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        check_result("reset_value", '0, result);
        build_table();
        for (int i = 0; i < N_RANDOM; i++) begin
            bits   = take_bits(3);
            rq.op  = muldiv_op_e'(bits[2:0]);
            rq.rs1 = take_bits(XW);
            rq.rs2 = take_bits(XW);
            bits   = take_bits(5);
            rq.rs2 = rq.rs2 >> bits[4:0];  // small divisors too
            add_vec($sformatf("random_%0d", i), rq.op, rq.rs1, rq.rs2,
                    ref_model(rq.op, rq.rs1, rq.rs2));
        end
        foreach (vecs[i]) begin
            run_vec(names[i], vecs[i], (i % 5) == 2);
        end
        if (dut0.u_checker.fail_count == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            fail_now("a bound assertion fired during the run");
        end
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+common
common/muldiv_pkg.sv
muldiv/operand_prep.sv
muldiv/shift_add_mul.sv
muldiv/restoring_div.sv
muldiv/result_fixup.sv
source/muldiv_ctrl.sv
source/muldiv_unit.sv
verification/muldiv_checker.sv
verification/muldiv_tb.sv
